// ==== rtl/mips_isa_pkg.sv ====
// MIPS instruction-set definitions
// Word and register types, opcode and function codes, field positions
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Hard-wired zero register
    localparam reg_addr_t REG_ZERO = 5'd0;

    // Primary opcodes of the supported subset
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_J     = 6'b000010;

    // R-type function codes
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // Instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
// Pipeline microarchitecture definitions
// Timing type, ALU codes, decoded controls, stage register structs,
// forward-select codes
`default_nettype none

package pipe_pkg;

    // Stages until a value exists, also used for stages until it is needed
    typedef logic [1:0] tnew_t;
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_SLT  = 3'd4;
    // Result already formed in decode (lui)
    localparam alu_op_t ALU_PASS = 3'd5;

    typedef struct packed {
        alu_op_t                 alu_op;
        logic                    use_imm;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
        mips_isa_pkg::reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        mips_isa_pkg::word_t     rs_val;
        mips_isa_pkg::word_t     rt_val;
        mips_isa_pkg::reg_addr_t rs;
        mips_isa_pkg::reg_addr_t rt;
        mips_isa_pkg::word_t     imm;
        mips_isa_pkg::word_t     early_result;
        tnew_t                   tnew;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        mips_isa_pkg::word_t     alu_result;
        mips_isa_pkg::word_t     store_data;
        mips_isa_pkg::reg_addr_t rt;
        tnew_t                   tnew;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        mips_isa_pkg::reg_addr_t dest;
        mips_isa_pkg::word_t     result;
    } mem_wb_t;

    // Decode operand sources
    typedef logic [1:0] fwd_id_t;
    localparam fwd_id_t FWD_ID_RF    = 2'd0;
    localparam fwd_id_t FWD_ID_IDEX  = 2'd1;
    localparam fwd_id_t FWD_ID_EXMEM = 2'd2;
    localparam fwd_id_t FWD_ID_WB    = 2'd3;

    // Execute operand sources
    typedef logic [1:0] fwd_ex_t;
    localparam fwd_ex_t FWD_EX_PIPE  = 2'd0;
    localparam fwd_ex_t FWD_EX_EXMEM = 2'd1;
    localparam fwd_ex_t FWD_EX_WB    = 2'd2;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
// General-purpose register file
// Two read ports, one write port, register zero reads as zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    input  mips_isa_pkg::reg_addr_t wr_addr,
    input  logic                    wr_en,
    input  mips_isa_pkg::word_t     wr_data,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data
);
    import mips_isa_pkg::*;

    word_t regs [32];
    logic  write_hit;

    // No writes while the core is held in reset
    assign write_hit = reset && wr_en && (wr_addr != REG_ZERO);

    always_ff @(posedge clk) begin
        if (write_hit) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-before-read bypass for the decode stage
    always_comb begin
        rs_data = regs[rs_addr];
        rt_data = regs[rt_addr];
        if (write_hit && (wr_addr == rs_addr)) begin
            rs_data = wr_data;
        end
        if (write_hit && (wr_addr == rt_addr)) begin
            rt_data = wr_data;
        end
        if (rs_addr == REG_ZERO) begin
            rs_data = '0;
        end
        if (rt_addr == REG_ZERO) begin
            rt_data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
// Instruction decoder for the decode stage
// Controls, use and new-value times, immediates, branch compare
// and next-PC target
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  mips_isa_pkg::word_t     instr,
    input  mips_isa_pkg::word_t     pc_plus4,
    input  mips_isa_pkg::word_t     rs_val,
    input  mips_isa_pkg::word_t     rt_val,
    output pipe_pkg::ctrl_t         ctrl,
    output mips_isa_pkg::reg_addr_t rs_addr,
    output mips_isa_pkg::reg_addr_t rt_addr,
    output logic                    rs_used,
    output logic                    rt_used,
    output pipe_pkg::tnew_t         rs_tuse,
    output pipe_pkg::tnew_t         rt_tuse,
    output pipe_pkg::tnew_t         tnew,
    output mips_isa_pkg::word_t     imm,
    output mips_isa_pkg::word_t     early_result,
    output logic                    take_jump,
    output mips_isa_pkg::word_t     jump_target
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd_addr;
    word_t      imm_sext;
    word_t      imm_zext;
    logic       is_beq;
    logic       is_j;

    assign opcode  = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct   = instr[FUNCT_LSB +: 6];
    assign rs_addr = instr[RS_LSB +: 5];
    assign rt_addr = instr[RT_LSB +: 5];
    assign rd_addr = instr[RD_LSB +: 5];

    assign imm_sext     = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext     = {16'b0, instr[15:0]};
    assign early_result = {instr[15:0], 16'b0};

    always_comb begin
        ctrl    = '0;
        rs_used = 1'b0;
        rt_used = 1'b0;
        rs_tuse = 2'd0;
        rt_tuse = 2'd0;
        tnew    = 2'd0;
        imm     = imm_sext;
        is_beq  = 1'b0;
        is_j    = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                rs_used        = 1'b1;
                rt_used        = 1'b1;
                rs_tuse        = 2'd1;
                rt_tuse        = 2'd1;
                tnew           = 2'd1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rd_addr;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: begin
                        // nop and unsupported functions do nothing
                        ctrl.reg_write = 1'b0;
                        rs_used        = 1'b0;
                        rt_used        = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI: begin
                rs_used        = 1'b1;
                rs_tuse        = 2'd1;
                tnew           = 2'd1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rt_addr;
                ctrl.alu_op    = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
                imm            = (opcode == OP_ORI) ? imm_zext : imm_sext;
            end
            OP_LUI: begin
                // Value known in decode, forwardable at once
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rt_addr;
                ctrl.alu_op    = ALU_PASS;
            end
            OP_LW: begin
                rs_used        = 1'b1;
                rs_tuse        = 2'd1;
                tnew           = 2'd2;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rt_addr;
            end
            OP_SW: begin
                // Store data only needed in the memory stage
                rs_used        = 1'b1;
                rt_used        = 1'b1;
                rs_tuse        = 2'd1;
                rt_tuse        = 2'd2;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                is_beq  = 1'b1;
            end
            OP_J: begin
                is_j = 1'b1;
            end
            default: begin
                is_j = 1'b0;
            end
        endcase
        // Writes to register zero are dropped here
        if (ctrl.dest == REG_ZERO) begin
            ctrl.reg_write = 1'b0;
        end
        if (!ctrl.reg_write) begin
            ctrl.dest = REG_ZERO;
        end
    end

    // Targets are relative to the delay-slot address
    assign take_jump   = is_j || (is_beq && (rs_val == rt_val));
    assign jump_target = is_j ? {pc_plus4[31:28], instr[25:0], 2'b00}
                              : pc_plus4 + (imm_sext << 2);

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// Hazard detection and forward selection
// Stall from use versus new-value times, operand sources for
// decode, execute and the store data of the memory stage
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  mips_isa_pkg::reg_addr_t rs_addr,
    input  mips_isa_pkg::reg_addr_t rt_addr,
    input  logic                    rs_used,
    input  logic                    rt_used,
    input  pipe_pkg::tnew_t         rs_tuse,
    input  pipe_pkg::tnew_t         rt_tuse,
    input  pipe_pkg::id_ex_t        id_ex,
    input  pipe_pkg::ex_mem_t       ex_mem,
    input  mips_isa_pkg::reg_addr_t wb_dest,
    output logic                    stall,
    output pipe_pkg::fwd_id_t       id_rs_sel,
    output pipe_pkg::fwd_id_t       id_rt_sel,
    output pipe_pkg::fwd_ex_t       ex_rs_sel,
    output pipe_pkg::fwd_ex_t       ex_rt_sel,
    output logic                    mem_rt_fwd
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic rs_stall;
    logic rt_stall;

    // Register zero never matches a destination
    function automatic logic hit(input reg_addr_t src, input reg_addr_t dest);
        return (src != REG_ZERO) && (src == dest);
    endfunction

    // Needed earlier than a later stage can deliver it
    function automatic logic must_wait(input reg_addr_t src, input tnew_t tuse,
                                       input id_ex_t idx, input ex_mem_t exm);
        return (hit(src, idx.ctrl.dest) && (tuse < idx.tnew)) ||
               (hit(src, exm.ctrl.dest) && (tuse < exm.tnew));
    endfunction

    // Nearest stage with a finished value wins
    function automatic fwd_id_t pick_id(input reg_addr_t src, input id_ex_t idx,
                                        input ex_mem_t exm, input reg_addr_t wbd);
        if (hit(src, idx.ctrl.dest) && (idx.tnew == 2'd0)) begin
            return FWD_ID_IDEX;
        end else if (hit(src, exm.ctrl.dest) && (exm.tnew == 2'd0)) begin
            return FWD_ID_EXMEM;
        end else if (hit(src, wbd)) begin
            return FWD_ID_WB;
        end
        return FWD_ID_RF;
    endfunction

    function automatic fwd_ex_t pick_ex(input reg_addr_t src, input ex_mem_t exm,
                                        input reg_addr_t wbd);
        if (hit(src, exm.ctrl.dest) && (exm.tnew == 2'd0)) begin
            return FWD_EX_EXMEM;
        end else if (hit(src, wbd)) begin
            return FWD_EX_WB;
        end
        return FWD_EX_PIPE;
    endfunction

    assign rs_stall = rs_used && must_wait(rs_addr, rs_tuse, id_ex, ex_mem);
    assign rt_stall = rt_used && must_wait(rt_addr, rt_tuse, id_ex, ex_mem);
    assign stall    = rs_stall || rt_stall;

    assign id_rs_sel = pick_id(rs_addr, id_ex, ex_mem, wb_dest);
    assign id_rt_sel = pick_id(rt_addr, id_ex, ex_mem, wb_dest);
    assign ex_rs_sel = pick_ex(id_ex.rs, ex_mem, wb_dest);
    assign ex_rt_sel = pick_ex(id_ex.rt, ex_mem, wb_dest);

    // Load result reaching a store right behind it
    assign mem_rt_fwd = hit(ex_mem.rt, wb_dest);

endmodule

`default_nettype wire

// ==== rtl/exec_alu.sv ====
// Execute-stage ALU
// Operand select, arithmetic and logic, new-value time countdown
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  pipe_pkg::id_ex_t    id_ex,
    input  mips_isa_pkg::word_t rs_val,
    input  mips_isa_pkg::word_t rt_val,
    output mips_isa_pkg::word_t result,
    output pipe_pkg::tnew_t     tnew_next
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    word_t op_b;

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rt_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:  result = rs_val + op_b;
            ALU_SUB:  result = rs_val - op_b;
            ALU_AND:  result = rs_val & op_b;
            ALU_OR:   result = rs_val | op_b;
            ALU_SLT:  result = {31'b0, $signed(rs_val) < $signed(op_b)};
            ALU_PASS: result = id_ex.early_result;
            default:  result = '0;
        endcase
    end

    // One stage closer to a finished value
    assign tnew_next = (id_ex.tnew == 2'd0) ? 2'd0 : id_ex.tnew - 2'd1;

endmodule

`default_nettype wire

// ==== rtl/mips_pipeline.sv ====
// Five-stage pipelined MIPS core
// PC, stage registers, forward muxes, memory and write-back ports
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    reset,
    output mips_isa_pkg::word_t     imem_addr,
    input  mips_isa_pkg::word_t     imem_data,
    output mips_isa_pkg::word_t     dmem_addr,
    output mips_isa_pkg::word_t     dmem_wdata,
    output logic                    dmem_we,
    input  mips_isa_pkg::word_t     dmem_rdata,
    output logic                    wb_valid,
    output mips_isa_pkg::reg_addr_t wb_reg,
    output mips_isa_pkg::word_t     wb_data
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    word_t     pc;
    word_t     pc_plus4;
    word_t     if_id_instr;
    word_t     if_id_pc_plus4;

    ctrl_t     id_ctrl;
    reg_addr_t id_rs_addr;
    reg_addr_t id_rt_addr;
    logic      id_rs_used;
    logic      id_rt_used;
    tnew_t     id_rs_tuse;
    tnew_t     id_rt_tuse;
    tnew_t     id_tnew;
    word_t     id_imm;
    word_t     id_early_result;
    logic      id_take_jump;
    word_t     id_jump_target;
    word_t     rf_rs_data;
    word_t     rf_rt_data;
    word_t     id_rs_val;
    word_t     id_rt_val;

    logic      stall;
    fwd_id_t   id_rs_sel;
    fwd_id_t   id_rt_sel;
    fwd_ex_t   ex_rs_sel;
    fwd_ex_t   ex_rt_sel;
    logic      mem_rt_fwd;

    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    word_t     ex_rs_val;
    word_t     ex_rt_val;
    word_t     ex_result;
    tnew_t     ex_tnew_next;
    word_t     mem_result;
    reg_addr_t wb_dest;

    assign pc_plus4  = pc + 32'd4;
    assign imem_addr = pc;

    // Fetch holds while decode waits; the delay slot is already in flight
    always_ff @(posedge clk) begin
        if (!reset) begin
            pc             <= RESET_PC;
            if_id_instr    <= '0;
            if_id_pc_plus4 <= '0;
        end else if (!stall) begin
            pc             <= id_take_jump ? id_jump_target : pc_plus4;
            if_id_instr    <= imem_data;
            if_id_pc_plus4 <= pc_plus4;
        end
    end

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (id_rs_addr),
        .rt_addr (id_rt_addr),
        .wr_addr (mem_wb.dest),
        .wr_en   (mem_wb.reg_write),
        .wr_data (mem_wb.result),
        .rs_data (rf_rs_data),
        .rt_data (rf_rt_data)
    );

    instr_decode u_decode (
        .instr        (if_id_instr),
        .pc_plus4     (if_id_pc_plus4),
        .rs_val       (id_rs_val),
        .rt_val       (id_rt_val),
        .ctrl         (id_ctrl),
        .rs_addr      (id_rs_addr),
        .rt_addr      (id_rt_addr),
        .rs_used      (id_rs_used),
        .rt_used      (id_rt_used),
        .rs_tuse      (id_rs_tuse),
        .rt_tuse      (id_rt_tuse),
        .tnew         (id_tnew),
        .imm          (id_imm),
        .early_result (id_early_result),
        .take_jump    (id_take_jump),
        .jump_target  (id_jump_target)
    );

    hazard_unit u_hazard (
        .rs_addr    (id_rs_addr),
        .rt_addr    (id_rt_addr),
        .rs_used    (id_rs_used),
        .rt_used    (id_rt_used),
        .rs_tuse    (id_rs_tuse),
        .rt_tuse    (id_rt_tuse),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .wb_dest    (wb_dest),
        .stall      (stall),
        .id_rs_sel  (id_rs_sel),
        .id_rt_sel  (id_rt_sel),
        .ex_rs_sel  (ex_rs_sel),
        .ex_rt_sel  (ex_rt_sel),
        .mem_rt_fwd (mem_rt_fwd)
    );

    // Decode operands for the branch compare and ID/EX
    always_comb begin
        case (id_rs_sel)
            FWD_ID_IDEX:  id_rs_val = id_ex.early_result;
            FWD_ID_EXMEM: id_rs_val = ex_mem.alu_result;
            FWD_ID_WB:    id_rs_val = mem_wb.result;
            default:      id_rs_val = rf_rs_data;
        endcase
        case (id_rt_sel)
            FWD_ID_IDEX:  id_rt_val = id_ex.early_result;
            FWD_ID_EXMEM: id_rt_val = ex_mem.alu_result;
            FWD_ID_WB:    id_rt_val = mem_wb.result;
            default:      id_rt_val = rf_rt_data;
        endcase
    end

    // A stall leaves a bubble behind the waiting instruction
    always_ff @(posedge clk) begin
        if (!reset || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{ctrl: id_ctrl, rs_val: id_rs_val, rt_val: id_rt_val,
                       rs: id_rs_addr, rt: id_rt_addr, imm: id_imm,
                       early_result: id_early_result, tnew: id_tnew};
        end
    end

    always_comb begin
        case (ex_rs_sel)
            FWD_EX_EXMEM: ex_rs_val = ex_mem.alu_result;
            FWD_EX_WB:    ex_rs_val = mem_wb.result;
            default:      ex_rs_val = id_ex.rs_val;
        endcase
        case (ex_rt_sel)
            FWD_EX_EXMEM: ex_rt_val = ex_mem.alu_result;
            FWD_EX_WB:    ex_rt_val = mem_wb.result;
            default:      ex_rt_val = id_ex.rt_val;
        endcase
    end

    exec_alu u_alu (
        .id_ex     (id_ex),
        .rs_val    (ex_rs_val),
        .rt_val    (ex_rt_val),
        .result    (ex_result),
        .tnew_next (ex_tnew_next)
    );

    always_ff @(posedge clk) begin
        if (!reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{ctrl: id_ex.ctrl, alu_result: ex_result, store_data: ex_rt_val,
                        rt: id_ex.rt, tnew: ex_tnew_next};
        end
    end

    // Memory stage
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = mem_rt_fwd ? mem_wb.result : ex_mem.store_data;
    assign dmem_we    = ex_mem.ctrl.mem_write;
    assign mem_result = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{reg_write: ex_mem.ctrl.reg_write, dest: ex_mem.ctrl.dest,
                        result: mem_result};
        end
    end

    // Decode already drops writes to register zero
    assign wb_dest  = mem_wb.dest;
    assign wb_valid = mem_wb.reg_write;
    assign wb_reg   = mem_wb.dest;
    assign wb_data  = mem_wb.result;

endmodule

`default_nettype wire

// ==== sim/pipeline_checker.sv ====
// Concurrent checks bound to the pipelined core
// Store alignment, write-back register, stall length
`timescale 1ns/1ps
`default_nettype none

module pipeline_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    dmem_we,
    input mips_isa_pkg::word_t     dmem_addr,
    input logic                    wb_valid,
    input mips_isa_pkg::reg_addr_t wb_reg,
    input logic                    stall
);
    import mips_isa_pkg::*;

    store_aligned: assert property (@(posedge clk) disable iff (!reset)
        dmem_we |-> (dmem_addr[1:0] == 2'b00))
        else $error("Store to unaligned address %h", dmem_addr);

    wb_not_zero: assert property (@(posedge clk) disable iff (!reset)
        wb_valid |-> (wb_reg != REG_ZERO))
        else $error("Write-back reported for register zero");

    // Worst case is a branch right behind a load
    stall_bounded: assert property (@(posedge clk) disable iff (!reset)
        (stall && $past(stall)) |-> !$past(stall, 2))
        else $error("Decode held for more than two cycles");

endmodule

bind mips_pipeline pipeline_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .dmem_we   (dmem_we),
    .dmem_addr (dmem_addr),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .stall     (stall)
);

`default_nettype wire

// ==== sim/tb_mips_pipeline.sv ====
// Testbench for the pipelined MIPS core
// Program table with expected results, instruction and data memory models,
// in-order write-back and store checks, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline;
    import mips_isa_pkg::*;

    localparam word_t      RESET_PC     = 32'h0000_0000;
    localparam int         PROG_LEN     = 29;
    localparam int         MAX_CYCLES   = PROG_LEN * 4 + 50;
    localparam int         RESET_CYCLES = 8;
    localparam int         DRAIN_CYCLES = 8;
    localparam logic [1:0] KIND_NONE    = 2'd0;
    localparam logic [1:0] KIND_WB      = 2'd1;
    localparam logic [1:0] KIND_LOADWB  = 2'd2;
    localparam logic [1:0] KIND_STORE   = 2'd3;

    // val is the result, the load addend or the store data
    typedef struct packed {
        word_t      instr;
        logic [1:0] kind;
        reg_addr_t  rd;
        word_t      val;
        word_t      addr;
    } prog_entry_t;

    logic        clk;
    logic        reset;
    word_t       imem_addr;
    word_t       imem_data;
    word_t       dmem_addr;
    word_t       dmem_wdata;
    logic        dmem_we;
    word_t       dmem_rdata;
    logic        wb_valid;
    reg_addr_t   wb_reg;
    word_t       wb_data;

    word_t       imem [64];
    word_t       dmem [64];
    prog_entry_t prog [PROG_LEN];
    int          wb_q[$];
    int          store_q[$];
    int          cycles = 0;

    mips_pipeline #(.RESET_PC(RESET_PC)) UUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    // Both memories answer in the same cycle
    assign imem_data  = (imem_addr[31:8] == '0) ? imem[imem_addr[7:2]] : '0;
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t xorshift32(input word_t x);
        word_t v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic word_t rtype_word(input logic [5:0] fn, input reg_addr_t rs,
                                         input reg_addr_t rt, input reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(input logic [25:0] index);
        return {OP_J, index};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic set_entry(input int i, input word_t instr, input logic [1:0] kind,
                             input reg_addr_t rd, input word_t val, input word_t addr);
        prog[i] = '{instr: instr, kind: kind, rd: rd, val: val, addr: addr};
    endtask

    task automatic build_program();
        // Dependent ALU chain
        set_entry(0, itype_word(OP_LUI, 5'd0, 5'd1, 16'h1234), KIND_WB, 5'd1, 32'h1234_0000, '0);
        set_entry(1, itype_word(OP_ORI, 5'd1, 5'd1, 16'h5678), KIND_WB, 5'd1, 32'h1234_5678, '0);
        set_entry(2, itype_word(OP_ADDIU, 5'd0, 5'd2, 16'h0010), KIND_WB, 5'd2, 32'h10, '0);
        set_entry(3, rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3), KIND_WB, 5'd3, 32'h1234_5688, '0);
        set_entry(4, rtype_word(FN_SUBU, 5'd3, 5'd1, 5'd4), KIND_WB, 5'd4, 32'h10, '0);
        set_entry(5, rtype_word(FN_AND, 5'd3, 5'd1, 5'd5), KIND_WB, 5'd5, 32'h1234_5608, '0);
        set_entry(6, rtype_word(FN_OR, 5'd5, 5'd4, 5'd6), KIND_WB, 5'd6, 32'h1234_5618, '0);
        set_entry(7, rtype_word(FN_SLT, 5'd4, 5'd3, 5'd7), KIND_WB, 5'd7, 32'h1, '0);
        set_entry(8, itype_word(OP_ADDIU, 5'd0, 5'd8, 16'hFFFC), KIND_WB, 5'd8, 32'hFFFF_FFFC, '0);
        set_entry(9, rtype_word(FN_SLT, 5'd8, 5'd7, 5'd9), KIND_WB, 5'd9, 32'h1, '0);
        // Register zero ignores writes and reads as zero
        set_entry(10, itype_word(OP_ADDIU, 5'd0, 5'd0, 16'h0055), KIND_NONE, 5'd0, '0, '0);
        set_entry(11, rtype_word(FN_ADDU, 5'd0, 5'd2, 5'd10), KIND_WB, 5'd10, 32'h10, '0);
        // Load with its user right behind
        set_entry(12, itype_word(OP_LW, 5'd2, 5'd11, 16'h0020), KIND_LOADWB, 5'd11, '0, 32'h30);
        set_entry(13, rtype_word(FN_ADDU, 5'd11, 5'd2, 5'd12), KIND_LOADWB, 5'd12, 32'h10,
                  32'h30);
        // Stores fed by the previous instruction
        set_entry(14, itype_word(OP_ADDIU, 5'd0, 5'd13, 16'h0BAD), KIND_WB, 5'd13, 32'hBAD, '0);
        set_entry(15, itype_word(OP_SW, 5'd2, 5'd13, 16'h0040), KIND_STORE, 5'd0, 32'hBAD, 32'h50);
        set_entry(16, itype_word(OP_LW, 5'd2, 5'd14, 16'h0040), KIND_LOADWB, 5'd14, '0, 32'h50);
        set_entry(17, itype_word(OP_SW, 5'd2, 5'd14, 16'h0044), KIND_STORE, 5'd0, 32'hBAD, 32'h54);
        // Taken beq skips entry 20
        set_entry(18, itype_word(OP_BEQ, 5'd14, 5'd13, 16'h0002), KIND_NONE, 5'd0, '0, '0);
        // Delay-slot load feeding the branch after it
        set_entry(19, itype_word(OP_LW, 5'd2, 5'd15, 16'h0040), KIND_LOADWB, 5'd15, '0, 32'h50);
        set_entry(20, itype_word(OP_ADDIU, 5'd0, 5'd16, 16'h0BAD), KIND_NONE, 5'd0, '0, '0);
        // Not taken, would land on entry 25
        set_entry(21, itype_word(OP_BEQ, 5'd15, 5'd0, 16'h0003), KIND_NONE, 5'd0, '0, '0);
        set_entry(22, itype_word(OP_ADDIU, 5'd0, 5'd17, 16'h0002), KIND_WB, 5'd17, 32'h2, '0);
        set_entry(23, jump_word(26'd26), KIND_NONE, 5'd0, '0, '0);
        set_entry(24, itype_word(OP_ADDIU, 5'd0, 5'd18, 16'h0003), KIND_WB, 5'd18, 32'h3, '0);
        set_entry(25, itype_word(OP_ADDIU, 5'd0, 5'd19, 16'h0077), KIND_NONE, 5'd0, '0, '0);
        set_entry(26, rtype_word(FN_ADDU, 5'd17, 5'd18, 5'd20), KIND_WB, 5'd20, 32'h5, '0);
        set_entry(27, itype_word(OP_SW, 5'd0, 5'd20, 16'h0000), KIND_STORE, 5'd0, 32'h5, 32'h0);
        set_entry(28, itype_word(OP_ORI, 5'd0, 5'd21, 16'h8001), KIND_WB, 5'd21, 32'h8001, '0);
    endtask

    task automatic check_reset_state();
        assert (wb_valid == 1'b0 && dmem_we == 1'b0 && imem_addr == RESET_PC)
        else abort_run($sformatf("FAIL t=%0t: reset state wb_valid=%b dmem_we=%b imem_addr=%h",
                                 $time, wb_valid, dmem_we, imem_addr));
    endtask

    task automatic check_writeback();
        int    idx;
        word_t expected;
        assert (wb_q.size() > 0)
        else abort_run($sformatf("FAIL t=%0t: unexpected write-back r%0d = %h",
                                 $time, wb_reg, wb_data));
        idx      = wb_q.pop_front();
        expected = prog[idx].val;
        // Load results come from the data model
        if (prog[idx].kind == KIND_LOADWB) begin
            expected = dmem[prog[idx].addr[7:2]] + prog[idx].val;
        end
        assert (wb_reg == prog[idx].rd && wb_data == expected)
        else abort_run($sformatf("FAIL t=%0t: entry %0d wrote r%0d = %h, expected r%0d = %h",
                                 $time, idx, wb_reg, wb_data, prog[idx].rd, expected));
    endtask

    task automatic check_store();
        int idx;
        assert (store_q.size() > 0)
        else abort_run($sformatf("FAIL t=%0t: unexpected store of %h to %h",
                                 $time, dmem_wdata, dmem_addr));
        idx = store_q.pop_front();
        assert (dmem_addr == prog[idx].addr && dmem_wdata == prog[idx].val)
        else abort_run($sformatf("FAIL t=%0t: entry %0d stored %h at %h, expected %h at %h",
                                 $time, idx, dmem_wdata, dmem_addr, prog[idx].val,
                                 prog[idx].addr));
        dmem[dmem_addr[7:2]] = dmem_wdata;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            if (wb_valid) begin
                check_writeback();
            end
            if (dmem_we) begin
                check_store();
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                abort_run($sformatf("Timeout: program not finished after %0d cycles",
                                    MAX_CYCLES));
            end
        end
    end

    initial begin
        word_t state;
        reset = 1'b0;
        state = 32'd38830;
        for (int i = 0; i < 64; i++) begin
            state   = xorshift32(state);
            dmem[i] = state ^ (word_t'(i) << 2);
            imem[i] = '0;
        end
        build_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = prog[i].instr;
            if (prog[i].kind == KIND_WB || prog[i].kind == KIND_LOADWB) begin
                wb_q.push_back(i);
            end else if (prog[i].kind == KIND_STORE) begin
                store_q.push_back(i);
            end
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b1;

        while (wb_q.size() != 0 || store_q.size() != 0) begin
            @(negedge clk);
        end
        // Catch late writes from skipped instructions
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/mips_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/hazard_unit.sv
rtl/exec_alu.sv
rtl/mips_pipeline.sv
sim/pipeline_checker.sv
sim/tb_mips_pipeline.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_mips_pipeline -Mdir obj_dir

./obj_dir/Vtb_mips_pipeline
